// File: Makefile
# Verilator build and run of the spindle host testbench
SIM      = verilator
SIMFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_spindle_top
FILELIST = compile.f
LOG      = sim.log
PASS_MSG = test passed

.PHONY: sim clean

# the log decides, the exit status follows the grep
sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+include
logic/spindle_pkg.sv
logic/param_decode.sv
logic/spike_window_execute.sv
logic/window_result.sv
logic/spindle_host_top.sv
tests/tb_clock_gen.sv
tests/spindle_checker.sv
tests/tb_spindle_top.sv

// File: include/spindle_defs.svh
`ifndef SPINDLE_DEFS_SVH
`define SPINDLE_DEFS_SVH

////////////////////////////////////////////////////////////
// parameter addresses on the command port
////////////////////////////////////////////////////////////
// bit 0 is the simulation enable
`define ADDR_CTRL       8'h00
`define ADDR_WINDOW     8'h01
`define ADDR_GAIN       8'h03

////////////////////////////////////////////////////////////
// reset values and limits
////////////////////////////////////////////////////////////
`define DEFAULT_WINDOW  16'd100
`define DEFAULT_GAIN    16'd1
// shortest window the bank will store
`define MIN_WINDOW      16'd8

// widths that carry a meaning
`define SPIKE_COUNT_W   16
`define DRIVE_W         32
`define TOTAL_W         32
`define ADDR_W          8
`define WORD_W          32
`define WINDOW_W        16
`define GAIN_W          16

`endif

// File: logic/param_decode.sv
`timescale 1ns/1ps

`include "spindle_defs.svh"

module param_decode
(
    input  logic                     i_ep50trig,
    input  logic                     i_reset_global,
    input  logic                     i_cmd_req,
    input  logic                     i_cmd_write,
    input  spindle_pkg::param_addr_t i_cmd_addr,
    input  spindle_pkg::param_word_t i_cmd_data,
    output logic                     o_cmd_ack,
    output spindle_pkg::param_word_t o_cmd_rdata,
    output logic                     o_enable,
    output spindle_pkg::window_len_t o_window_len,
    output spindle_pkg::gain_t       o_gain
);

    import spindle_pkg::*;

    hs_state_t   hs_state;
    logic        enable_q;
    window_len_t window_q;
    gain_t       gain_q;
    param_word_t rdata_q;
    window_len_t window_wr;
    param_word_t read_word;

    ////////////////////////////////////////////////////////////
    // write data shaping and readback mux
    ////////////////////////////////////////////////////////////

    // window clamp, too large saturates, too small goes to minimum
    always_comb
    begin
        if (|i_cmd_data[`WORD_W-1:`WINDOW_W])
            window_wr = '1;
        else if (i_cmd_data[`WINDOW_W-1:0] < `MIN_WINDOW)
            window_wr = `MIN_WINDOW;
        else
            window_wr = i_cmd_data[`WINDOW_W-1:0];
    end

    // unknown address reads as zero
    always_comb
    begin
        read_word = '0;
        case (i_cmd_addr)
            `ADDR_CTRL:   read_word[0] = enable_q;
            `ADDR_WINDOW: read_word[`WINDOW_W-1:0] = window_q;
            `ADDR_GAIN:   read_word[`GAIN_W-1:0] = gain_q;
            default:      read_word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // handshake FSM and register bank
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            hs_state <= HS_IDLE;
            enable_q <= 1'b0;
            window_q <= `DEFAULT_WINDOW;
            gain_q   <= `DEFAULT_GAIN;
            rdata_q  <= '0;
        end
        else
        begin
            case (hs_state)
                HS_IDLE:
                begin
                    // act once per request, ack rises on this edge
                    if (i_cmd_req)
                    begin
                        hs_state <= HS_ACKING;
                        if (i_cmd_write)
                        begin
                            case (i_cmd_addr)
                                `ADDR_CTRL:   enable_q <= i_cmd_data[0];
                                `ADDR_WINDOW: window_q <= window_wr;
                                `ADDR_GAIN:   gain_q   <= i_cmd_data[`GAIN_W-1:0];
                                // other addresses dropped, still acked
                                default:      enable_q <= enable_q;
                            endcase
                        end
                        else
                            rdata_q <= read_word;
                    end
                end
                HS_ACKING:
                begin
                    // hold ack and rdata until host drops req
                    if (!i_cmd_req)
                        hs_state <= HS_IDLE;
                end
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

    assign o_cmd_ack    = (hs_state == HS_ACKING);
    assign o_cmd_rdata  = rdata_q;
    assign o_enable     = enable_q;
    assign o_window_len = window_q;
    assign o_gain       = gain_q;

    // ack only ever rises from a sampled request
    a_ack_needs_req: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        $rose(o_cmd_ack) |-> $past(i_cmd_req))
        else $error("ack rose without a request");

endmodule

// File: logic/spike_window_execute.sv
`timescale 1ns/1ps

`include "spindle_defs.svh"

module spike_window_execute
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    input  logic                      i_spike,
    input  logic                      i_enable,
    input  spindle_pkg::window_len_t  i_window_len,
    input  spindle_pkg::gain_t        i_gain,
    output logic                      o_window_done,
    output spindle_pkg::spike_count_t o_window_count,
    output spindle_pkg::drive_t       o_drive
);

    import spindle_pkg::*;

    logic         spike_meta;
    logic         spike_sync;
    logic         spike_sync_d;
    logic         spike_rise;
    window_len_t  timer;
    window_len_t  len_q;
    gain_t        gain_q;
    spike_count_t count;
    spike_count_t count_next;
    logic         window_last;

    ////////////////////////////////////////////////////////////
    // spike input synchronizer and edge detect
    ////////////////////////////////////////////////////////////

    // two flops into the clock domain, third one for the edge
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            spike_meta   <= 1'b0;
            spike_sync   <= 1'b0;
            spike_sync_d <= 1'b0;
        end
        else
        begin
            spike_meta   <= i_spike;
            spike_sync   <= spike_meta;
            spike_sync_d <= spike_sync;
        end
    end

    assign spike_rise = spike_sync & ~spike_sync_d;

    // count including this cycle's edge, sticks at all ones
    always_comb
    begin
        if (spike_rise && (count != '1))
            count_next = count + 1'b1;
        else
            count_next = count;
    end

    ////////////////////////////////////////////////////////////
    // window timer and counter
    ////////////////////////////////////////////////////////////
    assign window_last = i_enable && (timer == len_q - 1'b1);

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            timer  <= '0;
            count  <= '0;
            len_q  <= `DEFAULT_WINDOW;
            gain_q <= `DEFAULT_GAIN;
        end
        else if (!i_enable || window_last)
        begin
            // idle or window end, next window starts from zero
            // length and gain frozen here for the coming window
            timer  <= '0;
            count  <= '0;
            len_q  <= i_window_len;
            gain_q <= i_gain;
        end
        else
        begin
            timer <= timer + 1'b1;
            count <= count_next;
        end
    end

    // results valid during the last cycle only
    assign o_window_done  = window_last;
    assign o_window_count = count_next;
    // 16x16 product fits the drive width
    assign o_drive        = drive_t'(count_next) * drive_t'(gain_q);

    // timer wraps at the length latched for this window
    a_timer_in_window: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        timer < len_q)
        else $error("window timer ran past latched length");

endmodule

// File: logic/spindle_host_top.sv
`timescale 1ns/1ps

module spindle_host_top
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    // host command port
    input  logic                      i_cmd_req,
    input  logic                      i_cmd_write,
    input  spindle_pkg::param_addr_t  i_cmd_addr,
    input  spindle_pkg::param_word_t  i_cmd_data,
    output logic                      o_cmd_ack,
    output spindle_pkg::param_word_t  o_cmd_rdata,
    // raw spike from the neuron board
    input  logic                      i_spike,
    // finished window report
    output spindle_pkg::spike_count_t o_window_count,
    output spindle_pkg::drive_t       o_drive,
    output spindle_pkg::total_t       o_total_spikes,
    output spindle_pkg::window_len_t  o_window_index,
    output logic                      o_window_valid
);

    import spindle_pkg::*;

    // tuning parameters, decode to execute
    logic         enable;
    window_len_t  window_len;
    gain_t        gain;

    // window end, execute to result
    logic         window_done;
    spike_count_t exec_count;
    drive_t       exec_drive;

    ////////////////////////////////////////////////////////////
    // command handshake and parameter bank
    ////////////////////////////////////////////////////////////
    param_decode u_param_decode
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_cmd_req      (i_cmd_req),
        .i_cmd_write    (i_cmd_write),
        .i_cmd_addr     (i_cmd_addr),
        .i_cmd_data     (i_cmd_data),
        .o_cmd_ack      (o_cmd_ack),
        .o_cmd_rdata    (o_cmd_rdata),
        .o_enable       (enable),
        .o_window_len   (window_len),
        .o_gain         (gain)
    );

    // spike sync, window count, gain multiply
    spike_window_execute u_spike_window_execute
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_spike        (i_spike),
        .i_enable       (enable),
        .i_window_len   (window_len),
        .i_gain         (gain),
        .o_window_done  (window_done),
        .o_window_count (exec_count),
        .o_drive        (exec_drive)
    );

    // registered report, running total and index
    window_result u_window_result
    (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_window_done  (window_done),
        .i_window_count (exec_count),
        .i_drive        (exec_drive),
        .o_window_count (o_window_count),
        .o_drive        (o_drive),
        .o_total_spikes (o_total_spikes),
        .o_window_index (o_window_index),
        .o_window_valid (o_window_valid)
    );

endmodule

// File: logic/spindle_pkg.sv
package spindle_pkg;

    `include "spindle_defs.svh"

    // spike count of one window, saturates
    typedef logic [`SPIKE_COUNT_W-1:0] spike_count_t;

    // count times gain, full product width
    typedef logic [`DRIVE_W-1:0] drive_t;

    // running spike total, wraps
    typedef logic [`TOTAL_W-1:0] total_t;

    // command port address and data
    typedef logic [`ADDR_W-1:0] param_addr_t;
    typedef logic [`WORD_W-1:0] param_word_t;

    // window length in clock cycles
    typedef logic [`WINDOW_W-1:0] window_len_t;

    // drive multiplier
    typedef logic [`GAIN_W-1:0] gain_t;

    // four-phase handshake machine
    typedef enum logic
    {
        HS_IDLE   = 1'b0,
        HS_ACKING = 1'b1
    } hs_state_t;

endpackage

// File: logic/window_result.sv
`timescale 1ns/1ps

module window_result
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    input  logic                      i_window_done,
    input  spindle_pkg::spike_count_t i_window_count,
    input  spindle_pkg::drive_t       i_drive,
    output spindle_pkg::spike_count_t o_window_count,
    output spindle_pkg::drive_t       o_drive,
    output spindle_pkg::total_t       o_total_spikes,
    output spindle_pkg::window_len_t  o_window_index,
    output logic                      o_window_valid
);

    import spindle_pkg::*;

    total_t count_ext;

    // widen window count before the running sum
    assign count_ext = total_t'(i_window_count);

    ////////////////////////////////////////////////////////////
    // per-window result registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            o_window_count <= '0;
            o_drive        <= '0;
            o_total_spikes <= '0;
            o_window_index <= '0;
            o_window_valid <= 1'b0;
        end
        else
        begin
            // one-cycle strobe, follows the done pulse
            o_window_valid <= i_window_done;
            if (i_window_done)
            begin
                o_window_count <= i_window_count;
                o_drive        <= i_drive;
                // total and index both wrap
                o_total_spikes <= o_total_spikes + count_ext;
                o_window_index <= o_window_index + 1'b1;
            end
        end
    end

    // windows are at least the minimum length apart
    a_valid_single: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        o_window_valid |=> !o_window_valid)
        else $error("window valid held for two cycles");

endmodule

// File: tests/spindle_checker.sv
`timescale 1ns/1ps

`include "spindle_defs.svh"

module spindle_checker
(
    input  logic                      i_ep50trig,
    input  logic                      i_reset_global,
    input  logic                      i_cmd_req,
    input  logic                      i_cmd_write,
    input  spindle_pkg::param_addr_t  i_cmd_addr,
    input  spindle_pkg::param_word_t  i_cmd_data,
    input  logic                      i_cmd_ack,
    input  spindle_pkg::param_word_t  i_cmd_rdata,
    input  spindle_pkg::spike_count_t i_window_count,
    input  spindle_pkg::drive_t       i_drive,
    input  spindle_pkg::total_t       i_total_spikes,
    input  spindle_pkg::window_len_t  i_window_index,
    input  logic                      i_window_valid,
    // window announcements and test markers from the stimulus
    input  logic                      i_exp_strobe,
    input  int                        i_exp_spikes,
    input  spindle_pkg::gain_t        i_exp_gain,
    input  logic                      i_test_end,
    input  int                        i_test_id,
    input  logic                      i_report,
    output int                        o_errors,
    output int                        o_pending
);

    import spindle_pkg::*;

    // inputs as the DUT saw them at the last rising edge
    logic rst_s = 1'b1;
    logic req_s;
    logic wr_s;
    logic strobe_s;
    logic end_s;
    logic report_s;
    param_addr_t addr_s;
    param_word_t data_s;
    int spikes_s;
    int id_s;
    gain_t gain_s;

    // register bank and handshake model
    logic acking;
    logic m_enable;
    window_len_t m_window;
    gain_t m_gain;
    param_word_t m_rdata;
    // length of the window now open, and the one latched at its end
    window_len_t m_len;
    window_len_t len_next;
    // expected result outputs
    spike_count_t m_count;
    drive_t m_drive;
    total_t m_total;
    window_len_t m_index;

    int spikes_q[$];
    gain_t gain_q[$];
    int cyc = 0;
    int last_valid = 0;
    int checks = 0;
    int checks_mark = 0;
    int errors_mark = 0;
    int spk;
    gain_t g;

    initial o_errors = 0;

    ////////////////////////////////////////////////////////////
    // reference model of one finished window
    ////////////////////////////////////////////////////////////
    // count saturates at 16 bits, drive is count times gain
    function automatic logic [47:0] predict_window(input int spikes, input gain_t gain);
        spike_count_t count;
        drive_t drive;
        if (spikes > 65535)
            count = 16'hffff;
        else
            count = 16'(spikes);
        drive = {16'd0, count} * {16'd0, gain};
        return {count, drive};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            o_errors++;
            $display("ERR %s expected %h got %h", name, exp, act);
        end
    endtask

    always @(posedge i_ep50trig)
    begin
        rst_s    <= i_reset_global;
        req_s    <= i_cmd_req;
        wr_s     <= i_cmd_write;
        addr_s   <= i_cmd_addr;
        data_s   <= i_cmd_data;
        strobe_s <= i_exp_strobe;
        spikes_s <= i_exp_spikes;
        gain_s   <= i_exp_gain;
        end_s    <= i_test_end;
        id_s     <= i_test_id;
        report_s <= i_report;
    end

    ////////////////////////////////////////////////////////////
    // compare on the falling edge, outputs settled by then
    ////////////////////////////////////////////////////////////
    always @(negedge i_ep50trig)
    begin
        cyc++;
        if (rst_s)
        begin
            acking   = 1'b0;
            m_enable = 1'b0;
            m_window = `DEFAULT_WINDOW;
            m_gain   = `DEFAULT_GAIN;
            m_rdata  = '0;
            m_len    = `DEFAULT_WINDOW;
            m_count  = '0;
            m_drive  = '0;
            m_total  = '0;
            m_index  = '0;
        end
        else
        begin
            // stored length before this edge's write, latched if a window ends here
            len_next = m_window;
            // idle and req high, act and ack on that edge
            if (!acking && req_s)
            begin
                acking = 1'b1;
                if (wr_s)
                begin
                    case (addr_s)
                        `ADDR_CTRL:
                        begin
                            // enable rising opens the first window
                            if (data_s[0] && !m_enable)
                            begin
                                last_valid = cyc;
                                m_len      = m_window;
                            end
                            m_enable = data_s[0];
                        end
                        `ADDR_WINDOW:
                        begin
                            // short windows raised to the minimum
                            if (data_s < 32'(`MIN_WINDOW))
                                m_window = `MIN_WINDOW;
                            else if (data_s > 32'h0000ffff)
                                m_window = 16'hffff;
                            else
                                m_window = data_s[15:0];
                        end
                        `ADDR_GAIN: m_gain = data_s[15:0];
                        default: ;
                    endcase
                end
                else
                begin
                    case (addr_s)
                        `ADDR_CTRL:   m_rdata = {31'd0, m_enable};
                        `ADDR_WINDOW: m_rdata = {16'd0, m_window};
                        `ADDR_GAIN:   m_rdata = {16'd0, m_gain};
                        default:      m_rdata = 32'd0;
                    endcase
                end
            end
            else if (acking && !req_s)
                acking = 1'b0;
            check_value("o_cmd_ack", 32'(acking), 32'(i_cmd_ack));
            if (acking)
                check_value("o_cmd_rdata", m_rdata, i_cmd_rdata);

            if (strobe_s)
            begin
                spikes_q.push_back(spikes_s);
                gain_q.push_back(gain_s);
            end

            // one announced window per valid pulse
            if (i_window_valid)
            begin
                if (spikes_q.size() == 0)
                begin
                    o_errors++;
                    $display("window reported at cycle %0d while none was expected", cyc);
                end
                else
                begin
                    spk = spikes_q.pop_front();
                    g   = gain_q.pop_front();
                    {m_count, m_drive} = predict_window(spk, g);
                    m_total = m_total + {16'd0, m_count};
                    m_index = m_index + 16'd1;
                    // window spans its latched length from enable or the previous end
                    check_value("window_gap", 32'(m_len), 32'(cyc - last_valid));
                end
                m_len      = len_next;
                last_valid = cyc;
            end
            // checked every cycle, so held values are covered too
            check_value("o_window_count", {16'd0, m_count}, {16'd0, i_window_count});
            check_value("o_drive", m_drive, i_drive);
            check_value("o_total_spikes", m_total, i_total_spikes);
            check_value("o_window_index", {16'd0, m_index}, {16'd0, i_window_index});
        end
        o_pending = spikes_q.size();

        if (end_s)
        begin
            $display("test %0d done: %0d checks, %0d errors", id_s,
                     checks - checks_mark, o_errors - errors_mark);
            checks_mark = checks;
            errors_mark = o_errors;
        end
        if (report_s)
        begin
            if (spikes_q.size() != 0)
            begin
                o_errors++;
                $display("%0d announced windows were never reported", spikes_q.size());
            end
            $display("all tests: %0d checks, %0d errors", checks, o_errors);
        end
    end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_ep50trig,
    output logic o_reset_global
);

    // starts low so the first edge is a rising one
    logic clk = 1'b0;

    assign o_ep50trig = clk;

    // 100 ns period
    initial
    begin
        forever #50 clk = ~clk;
    end

    // high across 5 rising edges, released on a falling edge
    initial
    begin
        o_reset_global = 1'b1;
        repeat (5) @(negedge clk);
        o_reset_global = 1'b0;
    end

endmodule

// File: tests/tb_spindle_top.sv
`timescale 1ns/1ps

`include "spindle_defs.svh"

module tb_spindle_top;

    import spindle_pkg::*;

    localparam int RUN_LEN = 40;
    // test 3 six, test 4 three, test 5 one cut short plus idle span plus two
    localparam int RUN_WINDOWS = 6 + 3 + 5;
    localparam int TIMEOUT_LIMIT = RUN_WINDOWS * RUN_LEN * 2 + 2000;

    logic ep50trig;
    logic reset_global;
    logic cmd_req;
    logic cmd_write;
    param_addr_t cmd_addr;
    param_word_t cmd_data;
    logic cmd_ack;
    param_word_t cmd_rdata;
    logic spike;
    spike_count_t window_count;
    drive_t drive;
    total_t total_spikes;
    window_len_t window_index;
    logic window_valid;

    // announcements to the checker
    logic exp_strobe;
    int exp_spikes;
    gain_t exp_gain;
    logic test_end;
    int test_id;
    logic report;
    int errors;
    int pending;

    int cyc = 0;
    int sched_errors;
    int ack_cyc;
    int base;
    int w;
    int n_spikes;
    integer seed;

    tb_clock_gen u_clock_gen
    (
        .o_ep50trig     (ep50trig),
        .o_reset_global (reset_global)
    );

    spindle_host_top uut
    (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_cmd_req      (cmd_req),
        .i_cmd_write    (cmd_write),
        .i_cmd_addr     (cmd_addr),
        .i_cmd_data     (cmd_data),
        .o_cmd_ack      (cmd_ack),
        .o_cmd_rdata    (cmd_rdata),
        .i_spike        (spike),
        .o_window_count (window_count),
        .o_drive        (drive),
        .o_total_spikes (total_spikes),
        .o_window_index (window_index),
        .o_window_valid (window_valid)
    );

    spindle_checker u_checker
    (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_cmd_req      (cmd_req),
        .i_cmd_write    (cmd_write),
        .i_cmd_addr     (cmd_addr),
        .i_cmd_data     (cmd_data),
        .i_cmd_ack      (cmd_ack),
        .i_cmd_rdata    (cmd_rdata),
        .i_window_count (window_count),
        .i_drive        (drive),
        .i_total_spikes (total_spikes),
        .i_window_index (window_index),
        .i_window_valid (window_valid),
        .i_exp_strobe   (exp_strobe),
        .i_exp_spikes   (exp_spikes),
        .i_exp_gain     (exp_gain),
        .i_test_end     (test_end),
        .i_test_id      (test_id),
        .i_report       (report),
        .o_errors       (errors),
        .o_pending      (pending)
    );

    // cycle number, read on falling edges
    always @(posedge ep50trig)
        cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////
    // stimulus tasks, entered right after a falling edge
    ////////////////////////////////////////////////////////////
    // four-phase command, returns the cycle where ack was seen
    task automatic host_cmd(input logic wr, input param_addr_t addr,
                            input param_word_t data, output int ack_at);
        cmd_write = wr;
        cmd_addr  = addr;
        cmd_data  = data;
        cmd_req   = 1'b1;
        do @(negedge ep50trig); while (!cmd_ack);
        ack_at  = cyc;
        cmd_req = 1'b0;
        do @(negedge ep50trig); while (cmd_ack);
        cmd_write = 1'b0;
    endtask

    task automatic wait_cycle(input int n);
        if (cyc > n)
        begin
            sched_errors++;
            $display("stimulus fell behind the window schedule at cycle %0d", cyc);
        end
        while (cyc < n)
            @(negedge ep50trig);
    endtask

    // 2 high and 2 low per spike
    task automatic spike_burst(input int start, input int count);
        int i;
        wait_cycle(start);
        for (i = 0; i < count; i++)
        begin
            spike = 1'b1;
            repeat (2) @(negedge ep50trig);
            spike = 1'b0;
            repeat (2) @(negedge ep50trig);
        end
    endtask

    // announce one window, then spikes well inside its edges
    task automatic run_window(input int start, input int count, input gain_t gain);
        wait_cycle(start + 3);
        exp_spikes = count;
        exp_gain   = gain;
        exp_strobe = 1'b1;
        @(negedge ep50trig);
        exp_strobe = 1'b0;
        spike_burst(start + 4, count);
    endtask

    task automatic wait_drained();
        do @(posedge ep50trig); while (pending != 0);
        @(negedge ep50trig);
    endtask

    task automatic end_test(input int id);
        test_id  = id;
        test_end = 1'b1;
        @(negedge ep50trig);
        test_end = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        seed = 32'hcc52;
        sched_errors = 0;
        cmd_req = 1'b0;
        cmd_write = 1'b0;
        cmd_addr = '0;
        cmd_data = '0;
        spike = 1'b0;
        exp_strobe = 1'b0;
        exp_spikes = 0;
        exp_gain = '0;
        test_end = 1'b0;
        test_id = 0;
        report = 1'b0;
        do @(posedge ep50trig); while (reset_global);
        @(negedge ep50trig);

        // reset defaults
        host_cmd(1'b0, `ADDR_CTRL, 32'd0, ack_cyc);
        host_cmd(1'b0, `ADDR_WINDOW, 32'd0, ack_cyc);
        host_cmd(1'b0, `ADDR_GAIN, 32'd0, ack_cyc);
        end_test(1);

        // readback, clamp, unknown address
        host_cmd(1'b1, `ADDR_WINDOW, 32'd5, ack_cyc);
        host_cmd(1'b0, `ADDR_WINDOW, 32'd0, ack_cyc);
        host_cmd(1'b1, `ADDR_WINDOW, 32'd250, ack_cyc);
        host_cmd(1'b0, `ADDR_WINDOW, 32'd0, ack_cyc);
        host_cmd(1'b1, `ADDR_GAIN, 32'd7, ack_cyc);
        host_cmd(1'b0, `ADDR_GAIN, 32'd0, ack_cyc);
        host_cmd(1'b1, 8'h02, 32'h1234, ack_cyc);
        host_cmd(1'b0, 8'h02, 32'd0, ack_cyc);
        end_test(2);

        // six back to back windows, first starts with the enable
        host_cmd(1'b1, `ADDR_WINDOW, 32'(RUN_LEN), ack_cyc);
        host_cmd(1'b1, `ADDR_GAIN, 32'd1, ack_cyc);
        host_cmd(1'b1, `ADDR_CTRL, 32'd1, base);
        for (w = 0; w < 6; w++)
        begin
            n_spikes = $unsigned($random(seed)) % 7;
            run_window(base + w * RUN_LEN, n_spikes, 16'd1);
        end
        wait_drained();
        end_test(3);

        // gain 3 written late in window 6, used from window 7
        // at least one spike each, so the gain shows in the drive
        n_spikes = 1 + $unsigned($random(seed)) % 6;
        run_window(base + 6 * RUN_LEN, n_spikes, 16'd1);
        wait_cycle(base + 6 * RUN_LEN + 30);
        host_cmd(1'b1, `ADDR_GAIN, 32'd3, ack_cyc);
        for (w = 7; w < 9; w++)
        begin
            n_spikes = 1 + $unsigned($random(seed)) % 6;
            run_window(base + w * RUN_LEN, n_spikes, 16'd3);
        end
        wait_drained();
        end_test(4);

        // window 9 cut short by the disable, spikes while off are dropped
        n_spikes = $unsigned($random(seed)) % 7;
        spike_burst(base + 9 * RUN_LEN + 4, n_spikes);
        wait_cycle(base + 9 * RUN_LEN + 30);
        host_cmd(1'b1, `ADDR_CTRL, 32'd0, ack_cyc);
        spike_burst(base + 10 * RUN_LEN, 5);
        wait_cycle(base + 10 * RUN_LEN + 30);
        host_cmd(1'b1, `ADDR_CTRL, 32'd1, base);
        for (w = 0; w < 2; w++)
        begin
            n_spikes = $unsigned($random(seed)) % 7;
            run_window(base + w * RUN_LEN, n_spikes, 16'd3);
        end
        wait_drained();
        end_test(5);

        report = 1'b1;
        @(negedge ep50trig);
        report = 1'b0;
        @(posedge ep50trig);
        if (errors == 0 && sched_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // hard stop well past the longest expected run
    initial
    begin
        do @(posedge ep50trig); while (cyc < TIMEOUT_LIMIT);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
        $display("test failed");
        $finish;
    end

endmodule
